//--- logic/cache_pkg.sv
`default_nettype none

package cache_pkg;

    // Address and data geometry
    parameter int ADDR_W         = 10;  // Byte address
    parameter int DATA_W         = 32;
    parameter int WORDS_PER_LINE = 4;
    parameter int WORD_SEL_W     = 2;   // Word inside a line
    parameter int BYTE_SEL_W     = 2;   // Byte inside a word

    // One LRU bit per set can only name one of two ways
    parameter int NUM_WAYS       = 2;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] word_t;

    // Whole word for word access, byte lanes for sb/lbu
    // Byte 0 is the least significant lane
    typedef union packed {
        word_t                          word;
        logic [DATA_W/8-1:0][7:0]       bytes;
    } cache_word_u;

    typedef logic way_t;

endpackage

`default_nettype wire

//--- logic/line_xfer_if.sv
`timescale 1ns/1ps
`default_nettype none

interface line_xfer_if import cache_pkg::*; ();

    logic  start;             // One-cycle kick from the controller
    logic  writeback;         // Victim is valid and dirty
    addr_t victim_line_addr;  // Base of the line to write back
    addr_t fill_line_addr;    // Base of the line to refill
    way_t  way;               // Way being replaced
    logic  busy;
    logic  finish;            // Pulse once the last refill word is in

    modport ctrl (
        output start,
        output writeback,
        output victim_line_addr,
        output fill_line_addr,
        output way,
        input  busy,
        input  finish
    );

    modport engine (
        input  start,
        input  writeback,
        input  victim_line_addr,
        input  fill_line_addr,
        input  way,
        output busy,
        output finish
    );

endinterface

`default_nettype wire

//--- logic/cache_tag_store.sv
`timescale 1ns/1ps
`default_nettype none

module cache_tag_store import cache_pkg::*; #(
    parameter  int SET_BITS = 1,
    localparam int TAG_W    = ADDR_W - SET_BITS - WORD_SEL_W - BYTE_SEL_W
) (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire addr_t            lookup_addr,
    input  wire logic             update_en,
    input  wire way_t             update_way,
    input  wire logic             update_dirty,
    input  wire logic             touch_en,
    output      logic             hit,
    output      way_t             hit_way,
    output      way_t             victim_way,
    output      logic             victim_valid,
    output      logic             victim_dirty,
    output      logic [TAG_W-1:0] victim_tag
);

    localparam int NUM_SETS = 1 << SET_BITS;
    localparam int OFF_W    = WORD_SEL_W + BYTE_SEL_W;

    logic [NUM_SETS-1:0][NUM_WAYS-1:0] valid_q;
    logic [NUM_SETS-1:0][NUM_WAYS-1:0] dirty_q;
    logic [NUM_SETS-1:0]               lru_q;      // Names the least recently used way
    logic [TAG_W-1:0]                  tag_q [NUM_SETS][NUM_WAYS];

    logic [SET_BITS-1:0] set_idx;
    logic [TAG_W-1:0]    lookup_tag;
    logic [NUM_WAYS-1:0] way_hit;

    assign set_idx    = lookup_addr[OFF_W +: SET_BITS];
    assign lookup_tag = lookup_addr[ADDR_W-1 -: TAG_W];

    // Both ways compared in parallel
    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            way_hit[w] = valid_q[set_idx][w] && (tag_q[set_idx][w] == lookup_tag);
        end
    end

    assign hit          = |way_hit;
    assign hit_way      = way_hit[1];
    assign victim_way   = lru_q[set_idx];
    assign victim_valid = valid_q[set_idx][victim_way];
    assign victim_dirty = dirty_q[set_idx][victim_way];
    assign victim_tag   = tag_q[set_idx][victim_way];

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
            dirty_q <= '0;
            lru_q   <= '0;
        end else begin
            if (update_en) begin                 // Line install after refill
                valid_q[set_idx][update_way] <= 1'b1;
                dirty_q[set_idx][update_way] <= update_dirty;
            end else if (touch_en && update_dirty) begin
                dirty_q[set_idx][update_way] <= 1'b1;  // Store hit
            end
            if (update_en || touch_en) begin
                lru_q[set_idx] <= ~update_way;   // Point away from the accessed way
            end
        end
    end

    always_ff @(posedge clk) begin
        if (update_en) begin
            tag_q[set_idx][update_way] <= lookup_tag;
        end
    end

endmodule

`default_nettype wire

//--- logic/cache_data_store.sv
`timescale 1ns/1ps
`default_nettype none

module cache_data_store import cache_pkg::*; #(
    parameter int SET_BITS = 1
) (
    input  wire logic                  clk,
    // CPU side, used for hits and the store merge
    input  wire addr_t                 cpu_addr,
    input  wire way_t                  cpu_way,
    input  wire logic                  cpu_we,
    input  wire logic                  cpu_byte,
    input  wire word_t                 cpu_wdata,
    // Line transfer side
    input  wire logic [SET_BITS-1:0]   fill_set,
    input  wire logic [WORD_SEL_W-1:0] fill_word,
    input  wire way_t                  fill_way,
    input  wire logic                  fill_we,
    input  wire word_t                 fill_wdata,
    output      word_t                 hit_word_a,
    output      word_t                 hit_word_b,
    output      word_t                 fill_rdata
);

    localparam int NUM_SETS = 1 << SET_BITS;
    localparam int OFF_W    = WORD_SEL_W + BYTE_SEL_W;

    cache_word_u mem_q [NUM_SETS][NUM_WAYS][WORDS_PER_LINE];

    logic [SET_BITS-1:0]   cpu_set;
    logic [WORD_SEL_W-1:0] cpu_word;
    logic [BYTE_SEL_W-1:0] cpu_lane;

    assign cpu_set  = cpu_addr[OFF_W +: SET_BITS];
    assign cpu_word = cpu_addr[BYTE_SEL_W +: WORD_SEL_W];
    assign cpu_lane = cpu_addr[BYTE_SEL_W-1:0];

    // The two ports never write in the same cycle
    always_ff @(posedge clk) begin
        if (fill_we) begin
            mem_q[fill_set][fill_way][fill_word].word <= fill_wdata;
        end else if (cpu_we) begin
            if (cpu_byte) begin
                mem_q[cpu_set][cpu_way][cpu_word].bytes[cpu_lane] <= cpu_wdata[7:0];
            end else begin
                mem_q[cpu_set][cpu_way][cpu_word].word <= cpu_wdata;
            end
        end
    end

    // Both ways read out, the controller picks one
    assign hit_word_a = mem_q[cpu_set][0][cpu_word].word;
    assign hit_word_b = mem_q[cpu_set][1][cpu_word].word;

    assign fill_rdata = mem_q[fill_set][fill_way][fill_word].word;  // Write-back source

endmodule

`default_nettype wire

//--- logic/line_transfer_engine.sv
`timescale 1ns/1ps
`default_nettype none

module line_transfer_engine import cache_pkg::*; #(
    parameter int SET_BITS = 1
) (
    input  wire logic                  clk,
    input  wire logic                  rst,
    line_xfer_if.engine                xfer,
    // Memory port
    input  wire logic                  mem_req_ready,
    input  wire logic                  mem_resp_valid,
    input  wire word_t                 mem_resp_data,
    output      logic                  mem_req_valid,
    output      logic                  mem_req_write,
    output      addr_t                 mem_req_addr,
    output      word_t                 mem_req_wdata,
    // Data store line port
    input  wire word_t                 fill_rdata,
    output      logic [SET_BITS-1:0]   fill_set,
    output      logic [WORD_SEL_W-1:0] fill_word,
    output      way_t                  fill_way,
    output      logic                  fill_we,
    output      word_t                 fill_wdata
);

    localparam int OFF_W = WORD_SEL_W + BYTE_SEL_W;
    localparam logic [WORD_SEL_W-1:0] LAST_BEAT = WORD_SEL_W'(WORDS_PER_LINE - 1);

    localparam logic [1:0] S_IDLE      = 2'd0;
    localparam logic [1:0] S_WRITE     = 2'd1;  // Victim write-back beats
    localparam logic [1:0] S_READ_REQ  = 2'd2;
    localparam logic [1:0] S_READ_WAIT = 2'd3;  // One read outstanding

    logic [1:0]            state_q;
    logic [WORD_SEL_W-1:0] beat_q;
    logic                  finish_q;
    addr_t                 line_base;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q  <= S_IDLE;
            beat_q   <= '0;
            finish_q <= 1'b0;
        end else begin
            finish_q <= 1'b0;
            case (state_q)
                S_IDLE: begin
                    if (xfer.start) begin
                        state_q <= xfer.writeback ? S_WRITE : S_READ_REQ;
                        beat_q  <= '0;
                    end
                end
                S_WRITE: begin
                    if (mem_req_ready) begin
                        beat_q <= beat_q + 1'b1;   // Wraps to 0 for the refill
                        if (beat_q == LAST_BEAT) begin
                            state_q <= S_READ_REQ;
                        end
                    end
                end
                S_READ_REQ: begin
                    if (mem_req_ready) begin
                        state_q <= S_READ_WAIT;
                    end
                end
                default: begin
                    if (mem_resp_valid) begin
                        beat_q <= beat_q + 1'b1;
                        if (beat_q == LAST_BEAT) begin
                            state_q  <= S_IDLE;
                            finish_q <= 1'b1;
                        end else begin
                            state_q <= S_READ_REQ;
                        end
                    end
                end
            endcase
        end
    end

    assign line_base = (state_q == S_WRITE) ? xfer.victim_line_addr : xfer.fill_line_addr;

    assign mem_req_valid = (state_q == S_WRITE) || (state_q == S_READ_REQ);
    assign mem_req_write = (state_q == S_WRITE);
    assign mem_req_addr  = {line_base[ADDR_W-1:OFF_W], beat_q, {BYTE_SEL_W{1'b0}}};
    assign mem_req_wdata = fill_rdata;

    // Victim and refill line share the set
    assign fill_set   = xfer.fill_line_addr[OFF_W +: SET_BITS];
    assign fill_word  = beat_q;
    assign fill_way   = xfer.way;
    assign fill_we    = (state_q == S_READ_WAIT) && mem_resp_valid;
    assign fill_wdata = mem_resp_data;

    assign xfer.busy   = (state_q != S_IDLE);
    assign xfer.finish = finish_q;

endmodule

`default_nettype wire

//--- logic/cache_controller.sv
`timescale 1ns/1ps
`default_nettype none

module cache_controller import cache_pkg::*; #(
    parameter  int SET_BITS = 1,
    localparam int TAG_W    = ADDR_W - SET_BITS - WORD_SEL_W - BYTE_SEL_W
) (
    input  wire logic             clk,
    input  wire logic             rst,
    // CPU request and response
    input  wire logic             req_valid,
    input  wire logic             req_write,
    input  wire logic             req_byte,
    input  wire addr_t            req_addr,
    input  wire word_t            req_wdata,
    output      logic             req_ready,
    output      logic             resp_valid,
    output      logic             resp_hit,
    output      word_t            resp_rdata,
    // Tag store
    input  wire logic             hit,
    input  wire way_t             hit_way,
    input  wire way_t             victim_way,
    input  wire logic             victim_valid,
    input  wire logic             victim_dirty,
    input  wire logic [TAG_W-1:0] victim_tag,
    output      addr_t            lookup_addr,
    output      logic             update_en,
    output      way_t             update_way,
    output      logic             update_dirty,
    output      logic             touch_en,
    // Data store CPU port
    input  wire word_t            hit_word_a,
    input  wire word_t            hit_word_b,
    output      addr_t            cpu_addr,
    output      way_t             cpu_way,
    output      logic             cpu_we,
    output      logic             cpu_byte,
    output      word_t            cpu_wdata,
    line_xfer_if.ctrl             xfer
);

    localparam int OFF_W = WORD_SEL_W + BYTE_SEL_W;

    localparam logic [1:0] S_IDLE    = 2'd0;
    localparam logic [1:0] S_LOOKUP  = 2'd1;
    localparam logic [1:0] S_REFILL  = 2'd2;
    localparam logic [1:0] S_RESPOND = 2'd3;

    logic [1:0]  state_q;
    logic        start_q;
    addr_t       addr_q;
    logic        write_q;
    logic        byte_q;
    word_t       wdata_q;
    logic        hit_q;
    way_t        way_q;       // Hit way, or the way being replaced
    logic        wb_q;
    addr_t       victim_base_q;
    logic        lookup_st;
    logic        merge_st;    // Refill just finished
    cache_word_u rd_word;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= S_IDLE;
            start_q <= 1'b0;
        end else begin
            start_q <= lookup_st && !hit;
            case (state_q)
                S_IDLE:    if (req_valid && req_ready) state_q <= S_LOOKUP;
                S_LOOKUP:  state_q <= hit ? S_RESPOND : S_REFILL;
                S_REFILL:  if (xfer.finish) state_q <= S_RESPOND;
                default:   state_q <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            addr_q  <= req_addr;
            write_q <= req_write;
            byte_q  <= req_byte;
            wdata_q <= req_wdata;
        end
        if (lookup_st) begin
            hit_q         <= hit;
            way_q         <= hit ? hit_way : victim_way;
            wb_q          <= victim_valid && victim_dirty;
            victim_base_q <= {victim_tag, addr_q[OFF_W +: SET_BITS], {OFF_W{1'b0}}};
        end
    end

    assign lookup_st = (state_q == S_LOOKUP);
    assign merge_st  = (state_q == S_REFILL) && xfer.finish;
    assign req_ready = (state_q == S_IDLE) && !xfer.busy;

    assign lookup_addr  = addr_q;
    assign touch_en     = lookup_st && hit;
    assign update_en    = merge_st;              // Tag install
    assign update_way   = lookup_st ? hit_way : way_q;
    assign update_dirty = write_q;

    // Store on a hit, or merge into the refilled line
    assign cpu_addr  = addr_q;
    assign cpu_way   = lookup_st ? hit_way : way_q;
    assign cpu_we    = write_q && (touch_en || merge_st);
    assign cpu_byte  = byte_q;
    assign cpu_wdata = wdata_q;

    assign xfer.start            = start_q;
    assign xfer.writeback        = wb_q;
    assign xfer.victim_line_addr = victim_base_q;
    assign xfer.fill_line_addr   = {addr_q[ADDR_W-1:OFF_W], {OFF_W{1'b0}}};
    assign xfer.way              = way_q;

    assign rd_word    = cache_word_u'(way_q ? hit_word_b : hit_word_a);
    assign resp_valid = (state_q == S_RESPOND);
    assign resp_hit   = hit_q;
    assign resp_rdata = write_q ? '0 :
                        byte_q  ? {{(DATA_W-8){1'b0}}, rd_word.bytes[addr_q[BYTE_SEL_W-1:0]]} :
                                  rd_word.word;   // lbu zero-extends

endmodule

`default_nettype wire

//--- logic/cache_top.sv
`timescale 1ns/1ps
`default_nettype none

module cache_top import cache_pkg::*; #(
    parameter  int SET_BITS = 1,
    localparam int TAG_W    = ADDR_W - SET_BITS - WORD_SEL_W - BYTE_SEL_W
) (
    input  wire logic  clk,
    input  wire logic  rst,
    // CPU side
    input  wire logic  req_valid,
    input  wire logic  req_write,
    input  wire logic  req_byte,
    input  wire addr_t req_addr,
    input  wire word_t req_wdata,
    output      logic  req_ready,
    output      logic  resp_valid,
    output      logic  resp_hit,
    output      word_t resp_rdata,
    // Main memory side
    input  wire logic  mem_req_ready,
    input  wire logic  mem_resp_valid,
    input  wire word_t mem_resp_data,
    output      logic  mem_req_valid,
    output      logic  mem_req_write,
    output      addr_t mem_req_addr,
    output      word_t mem_req_wdata
);

    line_xfer_if xfer ();

    addr_t                 lookup_addr;
    logic                  update_en;
    way_t                  update_way;
    logic                  update_dirty;
    logic                  touch_en;
    logic                  hit;
    way_t                  hit_way;
    way_t                  victim_way;
    logic                  victim_valid;
    logic                  victim_dirty;
    logic [TAG_W-1:0]      victim_tag;
    addr_t                 cpu_addr;
    way_t                  cpu_way;
    logic                  cpu_we;
    logic                  cpu_byte;
    word_t                 cpu_wdata;
    word_t                 hit_word_a;
    word_t                 hit_word_b;
    logic [SET_BITS-1:0]   fill_set;
    logic [WORD_SEL_W-1:0] fill_word;
    way_t                  fill_way;
    logic                  fill_we;
    word_t                 fill_wdata;
    word_t                 fill_rdata;

    cache_controller #(.SET_BITS(SET_BITS)) u_ctrl (
        .clk, .rst,
        .req_valid, .req_write, .req_byte, .req_addr, .req_wdata,
        .req_ready, .resp_valid, .resp_hit, .resp_rdata,
        .hit, .hit_way, .victim_way, .victim_valid, .victim_dirty, .victim_tag,
        .lookup_addr, .update_en, .update_way, .update_dirty, .touch_en,
        .hit_word_a, .hit_word_b,
        .cpu_addr, .cpu_way, .cpu_we, .cpu_byte, .cpu_wdata,
        .xfer (xfer.ctrl)
    );

    line_transfer_engine #(.SET_BITS(SET_BITS)) u_engine (
        .clk, .rst,
        .xfer (xfer.engine),
        .mem_req_ready, .mem_resp_valid, .mem_resp_data,
        .mem_req_valid, .mem_req_write, .mem_req_addr, .mem_req_wdata,
        .fill_rdata, .fill_set, .fill_word, .fill_way, .fill_we, .fill_wdata
    );

    cache_tag_store #(.SET_BITS(SET_BITS)) u_tags (
        .clk, .rst,
        .lookup_addr, .update_en, .update_way, .update_dirty, .touch_en,
        .hit, .hit_way, .victim_way, .victim_valid, .victim_dirty, .victim_tag
    );

    cache_data_store #(.SET_BITS(SET_BITS)) u_data (
        .clk,
        .cpu_addr, .cpu_way, .cpu_we, .cpu_byte, .cpu_wdata,
        .fill_set, .fill_word, .fill_way, .fill_we, .fill_wdata,
        .hit_word_a, .hit_word_b, .fill_rdata
    );

endmodule

`default_nettype wire

//--- verification/mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module mem_model import cache_pkg::*; #(
    parameter int    WORDS    = 256,
    parameter word_t FILL_KEY = 32'h5a3c_96e1
) (
    input  wire logic  clk,
    input  wire logic  rst,
    input  wire logic  req_valid,
    input  wire logic  req_write,
    input  wire addr_t req_addr,
    input  wire word_t req_wdata,
    output      logic  req_ready,
    output      logic  resp_valid,
    output      word_t resp_data
);

    word_t                        mem [WORDS];
    integer                       seed;
    int                           delay;
    logic                         pending;      // One read in flight at most
    logic [ADDR_W-BYTE_SEL_W-1:0] pend_idx;
    int                           write_count;  // Write log

    initial begin
        seed       = 90388;
        req_ready  = 1'b0;
        resp_valid = 1'b0;
        resp_data  = '0;
        for (int i = 0; i < WORDS; i++) begin
            mem[i] = {4{i[7:0]}} ^ FILL_KEY;
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            req_ready   <= 1'b0;
            resp_valid  <= 1'b0;
            resp_data   <= '0;
            pending     <= 1'b0;
            write_count <= 0;
        end else begin
            req_ready  <= ($random(seed) & 3) != 0;  // Stall about one cycle in four
            resp_valid <= 1'b0;
            if (req_valid && req_ready) begin
                if (req_write) begin
                    mem[req_addr >> BYTE_SEL_W] <= req_wdata;
                    write_count <= write_count + 1;
                end else begin
                    pending  <= 1'b1;
                    pend_idx <= req_addr >> BYTE_SEL_W;
                    delay    <= $random(seed) & 3;
                end
            end else if (pending) begin
                if (delay == 0) begin
                    resp_valid <= 1'b1;
                    resp_data  <= mem[pend_idx];
                    pending    <= 1'b0;
                end else begin
                    delay <= delay - 1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- verification/cache_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cache_tb import cache_pkg::*; ();

    localparam int    SET_BITS    = 1;
    localparam int    OFF_W       = WORD_SEL_W + BYTE_SEL_W;
    localparam int    TAG_W       = ADDR_W - SET_BITS - OFF_W;
    localparam int    NUM_SETS    = 1 << SET_BITS;
    localparam int    MEM_WORDS   = 1 << (ADDR_W - BYTE_SEL_W);
    localparam word_t FILL_KEY    = 32'h5a3c_96e1;
    localparam int    NUM_REQS    = 60;
    localparam int    MISS_CYCLES = 50;  // Lookup, 4 write beats, 4 read round trips
    localparam int    CYCLE_LIMIT = 10 * MISS_CYCLES * NUM_REQS;

    logic  clk;
    logic  rst;
    logic  req_valid;
    logic  req_write;
    logic  req_byte;
    addr_t req_addr;
    word_t req_wdata;
    logic  req_ready;
    logic  resp_valid;
    logic  resp_hit;
    word_t resp_rdata;
    logic  mem_req_ready;
    logic  mem_resp_valid;
    word_t mem_resp_data;
    logic  mem_req_valid;
    logic  mem_req_write;
    addr_t mem_req_addr;
    word_t mem_req_wdata;

    // Shadow memory holds what the CPU should see
    word_t            shadow_mem [MEM_WORDS];
    logic             s_valid [NUM_SETS][NUM_WAYS];
    logic             s_dirty [NUM_SETS][NUM_WAYS];
    logic [TAG_W-1:0] s_tag   [NUM_SETS][NUM_WAYS];
    logic             s_lru   [NUM_SETS];
    addr_t            beat_addr_q [$];   // Expected memory beats in order
    logic             beat_write_q [$];
    word_t            beat_data_q [$];
    logic             exp_hit;
    word_t            exp_rdata;
    int               exp_writes;        // Write beats the memory should have logged
    logic             pending;
    int               cycles;
    int               accept_cyc;
    integer           seed;
    logic [31:0]      rnd;
    addr_t            rnd_addr;
    logic             stalled;
    logic             held_write;
    addr_t            held_addr;
    word_t            held_wdata;

    cache_top #(.SET_BITS(SET_BITS)) u_dut (.*);

    mem_model #(.WORDS(MEM_WORDS), .FILL_KEY(FILL_KEY)) u_mem (
        .clk, .rst,
        .req_valid (mem_req_valid),
        .req_write (mem_req_write),
        .req_addr  (mem_req_addr),
        .req_wdata (mem_req_wdata),
        .req_ready (mem_req_ready),
        .resp_valid(mem_resp_valid),
        .resp_data (mem_resp_data)
    );

    always #20 clk = ~clk;

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Errors found");
        $fatal(1);
    endtask

    // Updates the shadow cache and queues the beats a request must cause
    task automatic predict(input logic write, input logic is_byte, input addr_t addr,
                           input word_t wdata);
        logic [SET_BITS-1:0] set_idx;
        logic [TAG_W-1:0]    tag;
        int                  way;
        int                  wi;
        addr_t               base;
        logic [7:0]          old_byte;
        set_idx = addr[OFF_W +: SET_BITS];
        tag     = addr[ADDR_W-1 -: TAG_W];
        wi      = int'(addr >> BYTE_SEL_W);
        way     = -1;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (s_valid[set_idx][w] && s_tag[set_idx][w] == tag)
                way = w;
        end
        exp_hit = (way >= 0);
        if (!exp_hit) begin
            way = s_lru[set_idx];
            if (s_valid[set_idx][way] && s_dirty[set_idx][way]) begin
                base = {s_tag[set_idx][way], set_idx, {OFF_W{1'b0}}};
                for (int b = 0; b < WORDS_PER_LINE; b++) begin
                    beat_addr_q.push_back(base + addr_t'(4 * b));
                    beat_write_q.push_back(1'b1);
                    beat_data_q.push_back(shadow_mem[(base >> BYTE_SEL_W) + b]);
                end
                exp_writes += WORDS_PER_LINE;
            end
            base = {addr[ADDR_W-1:OFF_W], {OFF_W{1'b0}}};
            for (int b = 0; b < WORDS_PER_LINE; b++) begin
                beat_addr_q.push_back(base + addr_t'(4 * b));
                beat_write_q.push_back(1'b0);
                beat_data_q.push_back('0);
            end
            s_valid[set_idx][way] = 1'b1;
            s_tag[set_idx][way]   = tag;
            s_dirty[set_idx][way] = write;  // Store refill leaves it dirty
        end else if (write) begin
            s_dirty[set_idx][way] = 1'b1;
        end
        s_lru[set_idx] = (way == 0);
        old_byte = shadow_mem[wi][8*addr[BYTE_SEL_W-1:0] +: 8];
        if (!write)
            exp_rdata = is_byte ? {24'h0, old_byte} : shadow_mem[wi];
        else begin
            exp_rdata = '0;
            if (is_byte)
                shadow_mem[wi][8*addr[BYTE_SEL_W-1:0] +: 8] = wdata[7:0];
            else
                shadow_mem[wi] = wdata;
        end
    endtask

    task automatic access(input logic write, input logic is_byte, input addr_t addr,
                          input word_t wdata);
        req_valid <= 1'b1;
        req_write <= write;
        req_byte  <= is_byte;
        req_addr  <= addr;
        req_wdata <= wdata;
        @(posedge clk);
        while (!req_ready)
            @(posedge clk);
        predict(write, is_byte, addr, wdata);  // Accepted on this edge
        accept_cyc = cycles;
        pending    = 1'b1;
        req_valid <= 1'b0;
        @(posedge clk);
        while (!resp_valid)
            @(posedge clk);
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT)
            fail_run("Timeout: the run did not finish within the cycle limit");
        if (rst) begin
            stalled <= 1'b0;
        end else begin
            if (stalled) begin  // Request held by a low ready
                assert (mem_req_valid) else fail_run($sformatf(
                    "[ERROR] %0t mem_req_valid got %b expected 1", $time, mem_req_valid));
                assert (mem_req_write == held_write) else fail_run($sformatf(
                    "[ERROR] %0t mem_req_write got %b expected %b", $time, mem_req_write,
                    held_write));
                assert (mem_req_addr == held_addr) else fail_run($sformatf(
                    "[ERROR] %0t mem_req_addr got %h expected %h", $time, mem_req_addr,
                    held_addr));
                assert (mem_req_wdata === held_wdata) else fail_run($sformatf(
                    "[ERROR] %0t mem_req_wdata got %h expected %h", $time, mem_req_wdata,
                    held_wdata));
            end
            if (mem_req_valid) begin
                assert (!req_ready) else fail_run($sformatf(
                    "[ERROR] %0t req_ready got %b expected 0", $time, req_ready));
            end
            if (mem_req_valid && mem_req_ready) begin
                assert (beat_addr_q.size() > 0) else fail_run($sformatf(
                    "Unexpected memory beat to address %h at %0t", mem_req_addr, $time));
                assert (mem_req_addr == beat_addr_q[0]) else fail_run($sformatf(
                    "[ERROR] %0t mem_req_addr got %h expected %h", $time, mem_req_addr,
                    beat_addr_q[0]));
                assert (mem_req_write == beat_write_q[0]) else fail_run($sformatf(
                    "[ERROR] %0t mem_req_write got %b expected %b", $time, mem_req_write,
                    beat_write_q[0]));
                if (beat_write_q[0]) begin
                    assert (mem_req_wdata == beat_data_q[0]) else fail_run($sformatf(
                        "[ERROR] %0t mem_req_wdata got %h expected %h", $time,
                        mem_req_wdata, beat_data_q[0]));
                end
                beat_addr_q.delete(0);
                beat_write_q.delete(0);
                beat_data_q.delete(0);
            end
            if (resp_valid) begin
                assert (pending) else fail_run("A response arrived with no request waiting");
                assert (resp_hit == exp_hit) else fail_run($sformatf(
                    "[ERROR] %0t resp_hit got %b expected %b", $time, resp_hit, exp_hit));
                assert (resp_rdata == exp_rdata) else fail_run($sformatf(
                    "[ERROR] %0t resp_rdata got %h expected %h", $time, resp_rdata,
                    exp_rdata));
                if (exp_hit) begin
                    assert (cycles - accept_cyc == 2) else fail_run($sformatf(
                        "[ERROR] %0t hit latency got %0d expected 2", $time,
                        cycles - accept_cyc));
                end
                assert (beat_addr_q.size() == 0) else fail_run($sformatf(
                    "Response at %0t came before all expected memory beats", $time));
                pending = 1'b0;
            end
            stalled    <= mem_req_valid && !mem_req_ready;
            held_write <= mem_req_write;
            held_addr  <= mem_req_addr;
            held_wdata <= mem_req_wdata;
        end
    end

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        req_valid  = 1'b0;
        req_write  = 1'b0;
        req_byte   = 1'b0;
        req_addr   = '0;
        req_wdata  = '0;
        cycles     = 0;
        pending    = 1'b0;
        stalled    = 1'b0;
        exp_writes = 0;
        seed       = 90388;
        for (int i = 0; i < MEM_WORDS; i++) begin
            shadow_mem[i] = {4{i[7:0]}} ^ FILL_KEY;
        end
        for (int s = 0; s < NUM_SETS; s++) begin
            s_lru[s] = 1'b0;
            for (int w = 0; w < NUM_WAYS; w++) begin
                s_valid[s][w] = 1'b0;
                s_dirty[s][w] = 1'b0;
                s_tag[s][w]   = '0;
            end
        end
        repeat (8) @(posedge clk);
        assert (req_ready && !resp_valid && !mem_req_valid)
            else fail_run("Outputs are not at their reset values after reset");
        rst <= 1'b0;
        @(posedge clk);
        access(1'b0, 1'b0, 10'h000, '0);           // Cold miss
        access(1'b0, 1'b0, 10'h004, '0);           // Hit on resident line
        access(1'b0, 1'b0, 10'h010, '0);
        access(1'b1, 1'b1, 10'h006, 32'h0000_00ab);
        access(1'b0, 1'b1, 10'h006, '0);           // lbu of the stored byte
        access(1'b0, 1'b0, 10'h004, '0);           // Merged word
        access(1'b0, 1'b0, 10'h020, '0);           // Second way of set 0
        access(1'b0, 1'b0, 10'h000, '0);           // Touch the first way
        access(1'b0, 1'b0, 10'h040, '0);           // Clean victim, no write beats
        access(1'b0, 1'b0, 10'h060, '0);           // Dirty victim written back
        access(1'b0, 1'b0, 10'h004, '0);           // Refill of written-back data
        access(1'b1, 1'b0, 10'h11c, 32'hdead_beef);  // Store miss allocates
        access(1'b0, 1'b1, 10'h11d, '0);
        repeat (NUM_REQS - 13) begin
            rnd      = $random(seed);
            rnd_addr = {3'b000, rnd[6:0]};         // Four tags per set
            if (!rnd[8])
                rnd_addr[BYTE_SEL_W-1:0] = '0;
            access(rnd[7], rnd[8], rnd_addr, $random(seed));
        end
        @(posedge clk);
        if (u_mem.write_count != exp_writes) begin
            fail_run($sformatf("[ERROR] %0t write_count got %0d expected %0d", $time,
                               u_mem.write_count, exp_writes));
        end else begin
            $display("No errors");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- cache_two_way.f
logic/cache_pkg.sv
logic/line_xfer_if.sv
logic/cache_tag_store.sv
logic/cache_data_store.sv
logic/line_transfer_engine.sv
logic/cache_controller.sv
logic/cache_top.sv
verification/mem_model.sv
verification/cache_tb.sv

//--- Bender.yml
package:
  name: cache_two_way

sources:
  - logic/cache_pkg.sv
  - logic/line_xfer_if.sv
  - logic/cache_tag_store.sv
  - logic/cache_data_store.sv
  - logic/line_transfer_engine.sv
  - logic/cache_controller.sv
  - logic/cache_top.sv
  - target: simulation
    files:
      - verification/mem_model.sv
      - verification/cache_tb.sv
